// File: source/io_hub_macros.svh
`ifndef IO_HUB_MACROS_SVH
`define IO_HUB_MACROS_SVH

// bus widths
`define IO_ADDR_W 16
`define IO_DATA_W 32
`define IO_SIZE_W 3

// hard disk 0, data block and aux port
`define HDD0_BASE 16'h01F0
`define HDD0_AUX 16'h03F6

// hard disk 1, data block and aux port
`define HDD1_BASE 16'h0170
`define HDD1_AUX 16'h0376

`define FDD_BASE 16'h03F0
`define PIT_BASE 16'h0040
`define PIT_SPK 16'h0061 // speaker control
`define PIC_M_BASE 16'h0020
`define PIC_S_BASE 16'h00A0
`define RTC_BASE 16'h0070
`define SYSCTL_PORT 16'h8888

// block alignment, log2 of block size
`define HDD_BLK_W 3
`define FDD_BLK_W 3
`define PIT_BLK_W 2
`define PIC_BLK_W 1
`define RTC_BLK_W 1

// system control port
`define SYSCTL_KEY 8'hA1
`define SYSCFG_RESET 8'hA2

`define OPEN_BUS 8'hFF // unmapped read value

`endif

// File: source/io_hub_pkg.sv
`default_nettype none

package io_hub_pkg;

	typedef enum logic [2:0] {
		IDLE,
		ADDR, // address on bus
		STROBE, // read or write pulse
		CAPTURE, // sample read data
		FINISH // done pulse
	} bus_state_t;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} io_op_t;

	// one select per target
	typedef struct packed {
		logic hdd0;
		logic hdd1;
		logic fdd;
		logic pit;
		logic pic;
		logic rtc;
		logic sysctl;
	} dev_cs_t;

endpackage

`default_nettype wire

// File: source/io_bus_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module io_bus_control (
	input wire clk_sys,
	input wire reset,

	input wire cpu_read_do,
	input wire [`IO_ADDR_W-1:0] cpu_read_address,
	input wire [`IO_SIZE_W-1:0] cpu_read_length,
	output logic [`IO_DATA_W-1:0] cpu_read_data,
	output logic cpu_read_done,

	input wire cpu_write_do,
	input wire [`IO_ADDR_W-1:0] cpu_write_address,
	input wire [`IO_SIZE_W-1:0] cpu_write_length,
	input wire [`IO_DATA_W-1:0] cpu_write_data,
	output logic cpu_write_done,

	output logic [`IO_ADDR_W-1:0] bus_address,
	output logic [`IO_DATA_W-1:0] bus_writedata,
	output logic [`IO_SIZE_W-1:0] bus_datasize,
	output logic bus_read,
	output logic bus_write,

	input wire io32,
	input wire [`IO_DATA_W-1:0] bus_readdata
);
	import io_hub_pkg::*;

	localparam logic [`IO_SIZE_W-1:0] SIZE_BYTE = 1;

	bus_state_t state_q;
	io_op_t op_q;
	logic [`IO_ADDR_W-1:0] addr_q;
	logic [`IO_SIZE_W-1:0] len_q;
	logic [`IO_SIZE_W-1:0] cnt_q; // bytes left
	logic [1:0] byte_q; // byte lane of next read byte
	logic [`IO_DATA_W-1:0] wdata_q;
	logic [`IO_DATA_W-1:0] rdata_q;
	logic first_q;
	logic wide_q;
	logic wide;
	logic last;

	// io32 is only trusted at the first STROBE, held in wide_q after that
	assign wide = first_q ? io32 : wide_q;
	assign last = wide_q || (cnt_q == SIZE_BYTE);

	assign bus_address = addr_q;
	assign bus_writedata = wdata_q;
	assign bus_datasize = wide ? len_q : SIZE_BYTE;
	assign bus_read = (state_q == STROBE) && (op_q == OP_READ);
	assign bus_write = (state_q == STROBE) && (op_q == OP_WRITE);

	assign cpu_read_data = rdata_q;
	assign cpu_read_done = (state_q == FINISH) && (op_q == OP_READ);
	assign cpu_write_done = (state_q == FINISH) && (op_q == OP_WRITE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q <= IDLE;
			op_q <= OP_READ;
			addr_q <= '0;
			first_q <= 1'b0;
			wide_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (cpu_read_do) begin // read wins a tie
						state_q <= ADDR;
						op_q <= OP_READ;
						addr_q <= cpu_read_address;
						first_q <= 1'b1;
					end else if (cpu_write_do) begin
						state_q <= ADDR;
						op_q <= OP_WRITE;
						addr_q <= cpu_write_address;
						first_q <= 1'b1;
					end
				end
				ADDR: begin
					state_q <= STROBE;
				end
				STROBE: begin
					state_q <= CAPTURE;
					first_q <= 1'b0;
					wide_q <= wide;
				end
				CAPTURE: begin
					if (last) begin
						state_q <= FINISH;
					end else begin
						state_q <= ADDR;
						addr_q <= addr_q + 1'b1; // next byte port
					end
				end
				FINISH: begin
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (state_q)
			IDLE: begin
				byte_q <= 2'd0;
				rdata_q <= '0; // unused upper bytes read as zero
				if (cpu_read_do) begin
					len_q <= cpu_read_length;
					cnt_q <= cpu_read_length;
				end else if (cpu_write_do) begin
					len_q <= cpu_write_length;
					cnt_q <= cpu_write_length;
					wdata_q <= cpu_write_data;
				end
			end
			CAPTURE: begin
				if (wide_q) begin
					rdata_q <= bus_readdata;
				end else begin
					rdata_q[{byte_q, 3'b000} +: 8] <= bus_readdata[7:0]; // little endian
				end
				if (!last) begin
					cnt_q <= cnt_q - 1'b1;
					byte_q <= byte_q + 1'b1;
					wdata_q <= wdata_q >> 8; // low byte goes first
				end
			end
			default: begin
				cnt_q <= cnt_q;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/port_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module port_decoder (
	input wire clk_sys,
	input wire reset,
	input wire [`IO_ADDR_W-1:0] bus_address,
	input wire bus_read,
	input wire bus_write,

	output io_hub_pkg::dev_cs_t cs,
	output logic io32,

	output logic hdd0_read,
	output logic hdd0_write,
	output logic hdd1_read,
	output logic hdd1_write,
	output logic fdd_read,
	output logic fdd_write,
	output logic pit_read,
	output logic pit_write,
	output logic pic_read,
	output logic pic_write,
	output logic rtc_read,
	output logic rtc_write
);
	logic hdd0_hit;
	logic hdd1_hit;
	logic fdd_hit;
	logic pit_hit;
	logic pic_hit;
	logic rtc_hit;
	logic sysctl_hit;

	// block aligned compares
	assign hdd0_hit = ((bus_address >> `HDD_BLK_W) == (`HDD0_BASE >> `HDD_BLK_W)) ||
		(bus_address == `HDD0_AUX);
	assign hdd1_hit = ((bus_address >> `HDD_BLK_W) == (`HDD1_BASE >> `HDD_BLK_W)) ||
		(bus_address == `HDD1_AUX);
	assign fdd_hit = (bus_address >> `FDD_BLK_W) == (`FDD_BASE >> `FDD_BLK_W);
	assign pit_hit = ((bus_address >> `PIT_BLK_W) == (`PIT_BASE >> `PIT_BLK_W)) ||
		(bus_address == `PIT_SPK);
	assign pic_hit = ((bus_address >> `PIC_BLK_W) == (`PIC_M_BASE >> `PIC_BLK_W)) ||
		((bus_address >> `PIC_BLK_W) == (`PIC_S_BASE >> `PIC_BLK_W)); // master or slave
	assign rtc_hit = (bus_address >> `RTC_BLK_W) == (`RTC_BASE >> `RTC_BLK_W);
	assign sysctl_hit = bus_address == `SYSCTL_PORT;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs <= '0;
			io32 <= 1'b0;
		end else begin
			cs.hdd0 <= hdd0_hit;
			cs.hdd1 <= hdd1_hit;
			cs.fdd <= fdd_hit;
			cs.pit <= pit_hit;
			cs.pic <= pic_hit;
			cs.rtc <= rtc_hit;
			cs.sysctl <= sysctl_hit;
			io32 <= ((hdd0_hit || hdd1_hit) && !bus_address[9]) || sysctl_hit; // aux ports are 8 bit
		end
	end

	assign hdd0_read = bus_read & cs.hdd0;
	assign hdd0_write = bus_write & cs.hdd0;
	assign hdd1_read = bus_read & cs.hdd1;
	assign hdd1_write = bus_write & cs.hdd1;
	assign fdd_read = bus_read & cs.fdd;
	assign fdd_write = bus_write & cs.fdd;
	assign pit_read = bus_read & cs.pit;
	assign pit_write = bus_write & cs.pit;
	assign pic_read = bus_read & cs.pic;
	assign pic_write = bus_write & cs.pic;
	assign rtc_read = bus_read & cs.rtc;
	assign rtc_write = bus_write & cs.rtc;

endmodule

`default_nettype wire

// File: source/read_mux.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module read_mux (
	input wire io_hub_pkg::dev_cs_t cs,
	input wire [`IO_DATA_W-1:0] hdd0_readdata,
	input wire [`IO_DATA_W-1:0] hdd1_readdata,
	input wire [7:0] fdd_readdata,
	input wire [7:0] pit_readdata,
	input wire [7:0] pic_readdata,
	input wire [7:0] rtc_readdata,
	output logic [`IO_DATA_W-1:0] bus_readdata
);
	logic [7:0] byte_rd;

	// 8 bit devices
	always_comb begin
		if (cs.fdd) begin
			byte_rd = fdd_readdata;
		end else if (cs.pic) begin
			byte_rd = pic_readdata;
		end else if (cs.pit) begin
			byte_rd = pit_readdata;
		end else if (cs.rtc) begin
			byte_rd = rtc_readdata;
		end else begin
			byte_rd = `OPEN_BUS;
		end
	end

	always_comb begin
		if (cs.hdd0) begin // disks win over the floppy block
			bus_readdata = hdd0_readdata;
		end else if (cs.hdd1) begin
			bus_readdata = hdd1_readdata;
		end else begin
			bus_readdata = {{(`IO_DATA_W-8){1'b0}}, byte_rd};
		end
	end

endmodule

`default_nettype wire

// File: source/sys_ctl_port.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module sys_ctl_port (
	input wire clk_sys,
	input wire reset,
	input wire io_hub_pkg::dev_cs_t cs,
	input wire bus_write,
	input wire [`IO_SIZE_W-1:0] bus_datasize,
	input wire [`IO_DATA_W-1:0] bus_writedata,
	output logic [7:0] syscfg
);
	localparam logic [`IO_SIZE_W-1:0] SIZE_WORD = 2;

	logic in_reset_q; // no disk access and no unlock yet
	logic disk_hit;
	logic unlock;

	assign disk_hit = cs.hdd0 | cs.hdd1 | cs.fdd;
	assign unlock = bus_write && cs.sysctl && (bus_datasize == SIZE_WORD) &&
		(bus_writedata[15:8] == `SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg <= `SYSCFG_RESET;
			in_reset_q <= 1'b1;
		end else if (disk_hit && in_reset_q) begin
			syscfg <= 8'h00; // first disk or floppy access
			in_reset_q <= 1'b0;
		end else if (unlock) begin
			syscfg <= bus_writedata[7:0];
			in_reset_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/io_hub.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module io_hub (
	input wire clk_sys,
	input wire reset,

	input wire cpu_read_do,
	input wire [`IO_ADDR_W-1:0] cpu_read_address,
	input wire [`IO_SIZE_W-1:0] cpu_read_length,
	output logic [`IO_DATA_W-1:0] cpu_read_data,
	output logic cpu_read_done,
	input wire cpu_write_do,
	input wire [`IO_ADDR_W-1:0] cpu_write_address,
	input wire [`IO_SIZE_W-1:0] cpu_write_length,
	input wire [`IO_DATA_W-1:0] cpu_write_data,
	output logic cpu_write_done,

	output logic [`IO_ADDR_W-1:0] dev_address,
	output logic [`IO_DATA_W-1:0] dev_writedata,
	output logic [`IO_SIZE_W-1:0] dev_datasize,

	output logic hdd0_read,
	output logic hdd0_write,
	output logic hdd1_read,
	output logic hdd1_write,
	output logic fdd_read,
	output logic fdd_write,
	output logic pit_read,
	output logic pit_write,
	output logic pic_read,
	output logic pic_write,
	output logic rtc_read,
	output logic rtc_write,

	input wire [`IO_DATA_W-1:0] hdd0_readdata,
	input wire [`IO_DATA_W-1:0] hdd1_readdata,
	input wire [7:0] fdd_readdata,
	input wire [7:0] pit_readdata,
	input wire [7:0] pic_readdata,
	input wire [7:0] rtc_readdata,

	output logic [7:0] syscfg
);
	import io_hub_pkg::*;

	logic [`IO_ADDR_W-1:0] bus_address;
	logic [`IO_DATA_W-1:0] bus_writedata;
	logic [`IO_SIZE_W-1:0] bus_datasize;
	logic [`IO_DATA_W-1:0] bus_readdata;
	logic bus_read;
	logic bus_write;
	logic io32;
	dev_cs_t cs;

	io_bus_control ctl (
		.clk_sys (clk_sys),
		.reset (reset),
		.cpu_read_do (cpu_read_do),
		.cpu_read_address (cpu_read_address),
		.cpu_read_length (cpu_read_length),
		.cpu_read_data (cpu_read_data),
		.cpu_read_done (cpu_read_done),
		.cpu_write_do (cpu_write_do),
		.cpu_write_address (cpu_write_address),
		.cpu_write_length (cpu_write_length),
		.cpu_write_data (cpu_write_data),
		.cpu_write_done (cpu_write_done),
		.bus_address (bus_address),
		.bus_writedata (bus_writedata),
		.bus_datasize (bus_datasize),
		.bus_read (bus_read),
		.bus_write (bus_write),
		.io32 (io32),
		.bus_readdata (bus_readdata)
	);

	port_decoder dec (
		.clk_sys (clk_sys),
		.reset (reset),
		.bus_address (bus_address),
		.bus_read (bus_read),
		.bus_write (bus_write),
		.cs (cs),
		.io32 (io32),
		.hdd0_read (hdd0_read),
		.hdd0_write (hdd0_write),
		.hdd1_read (hdd1_read),
		.hdd1_write (hdd1_write),
		.fdd_read (fdd_read),
		.fdd_write (fdd_write),
		.pit_read (pit_read),
		.pit_write (pit_write),
		.pic_read (pic_read),
		.pic_write (pic_write),
		.rtc_read (rtc_read),
		.rtc_write (rtc_write)
	);

	read_mux rmux (
		.cs (cs),
		.hdd0_readdata (hdd0_readdata),
		.hdd1_readdata (hdd1_readdata),
		.fdd_readdata (fdd_readdata),
		.pit_readdata (pit_readdata),
		.pic_readdata (pic_readdata),
		.rtc_readdata (rtc_readdata),
		.bus_readdata (bus_readdata)
	);

	sys_ctl_port sysctl (
		.clk_sys (clk_sys),
		.reset (reset),
		.cs (cs),
		.bus_write (bus_write),
		.bus_datasize (bus_datasize),
		.bus_writedata (bus_writedata),
		.syscfg (syscfg)
	);

	// shared device bus
	assign dev_address = bus_address;
	assign dev_writedata = bus_writedata;
	assign dev_datasize = bus_datasize;

endmodule

`default_nettype wire

// File: verif/io_hub_assert.sv
`timescale 1ns/10ps
`default_nettype none

module io_hub_assert (
	input wire clk_sys,
	input wire reset,
	input wire cpu_read_do,
	input wire cpu_write_do,
	input wire cpu_read_done,
	input wire cpu_write_done,
	input wire bus_read,
	input wire bus_write
);
	logic read_pending_q;
	logic write_pending_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			read_pending_q <= 1'b0;
			write_pending_q <= 1'b0;
		end else begin
			if (cpu_read_done) read_pending_q <= 1'b0;
			else if (cpu_read_do) read_pending_q <= 1'b1;
			if (cpu_write_done) write_pending_q <= 1'b0;
			else if (cpu_write_do && !cpu_read_do) write_pending_q <= 1'b1; // read wins a tie
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset) cpu_read_done |=> !cpu_read_done)
		else $error("cpu_read_done high for more than one cycle");
	assert property (@(posedge clk_sys) disable iff (reset) cpu_write_done |=> !cpu_write_done)
		else $error("cpu_write_done high for more than one cycle");
	assert property (@(posedge clk_sys) disable iff (reset) !(bus_read && bus_write))
		else $error("bus_read and bus_write high together");
	assert property (@(posedge clk_sys) disable iff (reset) cpu_read_done |-> read_pending_q)
		else $error("cpu_read_done without a read request");
	assert property (@(posedge clk_sys) disable iff (reset) cpu_write_done |-> write_pending_q)
		else $error("cpu_write_done without a write request");

endmodule

bind io_bus_control io_hub_assert protocol_check (
	.clk_sys (clk_sys),
	.reset (reset),
	.cpu_read_do (cpu_read_do),
	.cpu_write_do (cpu_write_do),
	.cpu_read_done (cpu_read_done),
	.cpu_write_done (cpu_write_done),
	.bus_read (bus_read),
	.bus_write (bus_write)
);

`default_nettype wire

// File: verif/io_hub_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "io_hub_macros.svh"

module io_hub_tb;
	localparam int CLK_PERIOD = 100;
	localparam int SINGLE_READS = 15;
	localparam int RANDOM_READS = 8;
	localparam int SPAN_READS = 8;
	localparam int ACCESS_COUNT = SINGLE_READS + RANDOM_READS + SPAN_READS + 10; // disk, sysctl and pit
	localparam int CYCLES_PER_ACCESS = 20;
	localparam int DEV_HDD0 = 0;
	localparam int DEV_HDD1 = 1;
	localparam int DEV_FDD = 2;
	localparam int DEV_PIT = 3;
	localparam int DEV_PIC = 4;
	localparam int DEV_RTC = 5;
	localparam int DEV_SYSCTL = 6;
	localparam logic [31:0] HDD0_TAG = 32'h5A5A_0F0F;
	localparam logic [31:0] HDD1_TAG = 32'hC3C3_3C3C;
	localparam logic [7:0] FDD_TAG = 8'h11;
	localparam logic [7:0] PIT_TAG = 8'h22;
	localparam logic [7:0] PIC_TAG = 8'h33;
	localparam logic [7:0] RTC_TAG = 8'h44;
	localparam logic [31:0] PIT_WDATA = 32'h1234_C07E;

	logic clk_sys;
	logic reset;
	logic cpu_read_do;
	logic [`IO_ADDR_W-1:0] cpu_read_address;
	logic [`IO_SIZE_W-1:0] cpu_read_length;
	logic [`IO_DATA_W-1:0] cpu_read_data;
	logic cpu_read_done;
	logic cpu_write_do;
	logic [`IO_ADDR_W-1:0] cpu_write_address;
	logic [`IO_SIZE_W-1:0] cpu_write_length;
	logic [`IO_DATA_W-1:0] cpu_write_data;
	logic cpu_write_done;
	logic [`IO_ADDR_W-1:0] dev_address;
	logic [`IO_DATA_W-1:0] dev_writedata;
	logic [`IO_SIZE_W-1:0] dev_datasize;
	logic [5:0] rd_strobes; // indexed by DEV_*
	logic [5:0] wr_strobes;
	logic [31:0] hdd0_readdata = '0;
	logic [31:0] hdd1_readdata = '0;
	logic [7:0] fdd_readdata = '0;
	logic [7:0] pit_readdata = '0;
	logic [7:0] pic_readdata = '0;
	logic [7:0] rtc_readdata = '0;
	logic [7:0] syscfg;

	integer seed;
	int rd_count [6];
	int wr_count [6];
	int issued_reads;
	int checked_reads;
	logic [31:0] exp_read_data;
	logic [15:0] pit_wr_addr [$];
	logic [7:0] pit_wr_byte [$];
	logic [`IO_SIZE_W-1:0] strobe_sizes [$];
	string dev_names [6] = '{"hdd0", "hdd1", "fdd", "pit", "pic", "rtc"};

	io_hub uut (
		.clk_sys (clk_sys),
		.reset (reset),
		.cpu_read_do (cpu_read_do),
		.cpu_read_address (cpu_read_address),
		.cpu_read_length (cpu_read_length),
		.cpu_read_data (cpu_read_data),
		.cpu_read_done (cpu_read_done),
		.cpu_write_do (cpu_write_do),
		.cpu_write_address (cpu_write_address),
		.cpu_write_length (cpu_write_length),
		.cpu_write_data (cpu_write_data),
		.cpu_write_done (cpu_write_done),
		.dev_address (dev_address),
		.dev_writedata (dev_writedata),
		.dev_datasize (dev_datasize),
		.hdd0_read (rd_strobes[DEV_HDD0]),
		.hdd0_write (wr_strobes[DEV_HDD0]),
		.hdd1_read (rd_strobes[DEV_HDD1]),
		.hdd1_write (wr_strobes[DEV_HDD1]),
		.fdd_read (rd_strobes[DEV_FDD]),
		.fdd_write (wr_strobes[DEV_FDD]),
		.pit_read (rd_strobes[DEV_PIT]),
		.pit_write (wr_strobes[DEV_PIT]),
		.pic_read (rd_strobes[DEV_PIC]),
		.pic_write (wr_strobes[DEV_PIC]),
		.rtc_read (rd_strobes[DEV_RTC]),
		.rtc_write (wr_strobes[DEV_RTC]),
		.hdd0_readdata (hdd0_readdata),
		.hdd1_readdata (hdd1_readdata),
		.fdd_readdata (fdd_readdata),
		.pit_readdata (pit_readdata),
		.pic_readdata (pic_readdata),
		.rtc_readdata (rtc_readdata),
		.syscfg (syscfg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// device models answer one clock after the read strobe
	always @(posedge clk_sys) begin
		if (rd_strobes[DEV_HDD0]) begin
			hdd0_readdata <= {dev_address, dev_address} ^ HDD0_TAG;
		end
		if (rd_strobes[DEV_HDD1]) begin
			hdd1_readdata <= {dev_address, dev_address} ^ HDD1_TAG;
		end
		if (rd_strobes[DEV_FDD]) begin
			fdd_readdata <= dev_address[7:0] ^ FDD_TAG;
		end
		if (rd_strobes[DEV_PIT]) begin
			pit_readdata <= dev_address[7:0] ^ PIT_TAG;
		end
		if (rd_strobes[DEV_PIC]) begin
			pic_readdata <= dev_address[7:0] ^ PIC_TAG;
		end
		if (rd_strobes[DEV_RTC]) begin
			rtc_readdata <= dev_address[7:0] ^ RTC_TAG;
		end
	end

	// strobe counters and logs
	always @(negedge clk_sys) begin
		for (int d = 0; d < 6; d++) begin
			if (rd_strobes[d]) begin
				rd_count[d]++;
			end
			if (wr_strobes[d]) begin
				wr_count[d]++;
			end
		end
		if ((rd_strobes | wr_strobes) != 6'd0) begin
			strobe_sizes.push_back(dev_datasize);
		end
		if (wr_strobes[DEV_PIT]) begin
			pit_wr_addr.push_back(dev_address);
			pit_wr_byte.push_back(dev_writedata[7:0]);
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	function automatic logic [6:0] port_hits(input logic [15:0] a);
		logic [6:0] h;
		h = '0;
		h[DEV_HDD0] = (a >= `HDD0_BASE && a < `HDD0_BASE + 16'd8) || a == `HDD0_AUX;
		h[DEV_HDD1] = (a >= `HDD1_BASE && a < `HDD1_BASE + 16'd8) || a == `HDD1_AUX;
		h[DEV_FDD] = a >= `FDD_BASE && a < `FDD_BASE + 16'd8;
		h[DEV_PIT] = (a >= `PIT_BASE && a < `PIT_BASE + 16'd4) || a == `PIT_SPK;
		h[DEV_PIC] = (a >= `PIC_M_BASE && a < `PIC_M_BASE + 16'd2) ||
			(a >= `PIC_S_BASE && a < `PIC_S_BASE + 16'd2);
		h[DEV_RTC] = a >= `RTC_BASE && a < `RTC_BASE + 16'd2;
		h[DEV_SYSCTL] = a == `SYSCTL_PORT;
		return h;
	endfunction

	function automatic logic is_wide(input logic [15:0] a);
		logic [6:0] h;
		h = port_hits(a);
		return ((h[DEV_HDD0] || h[DEV_HDD1]) && !a[9]) || h[DEV_SYSCTL]; // aux ports excluded
	endfunction

	function automatic logic [7:0] expected_byte(input logic [15:0] a);
		logic [6:0] h;
		h = port_hits(a);
		if (h[DEV_HDD0]) return a[7:0] ^ HDD0_TAG[7:0]; // low byte of the disk word
		else if (h[DEV_HDD1]) return a[7:0] ^ HDD1_TAG[7:0];
		else if (h[DEV_FDD]) return a[7:0] ^ FDD_TAG;
		else if (h[DEV_PIT]) return a[7:0] ^ PIT_TAG;
		else if (h[DEV_PIC]) return a[7:0] ^ PIC_TAG;
		else if (h[DEV_RTC]) return a[7:0] ^ RTC_TAG;
		else return `OPEN_BUS;
	endfunction

	// reference read result of one CPU access
	function automatic logic [31:0] expected_read(input logic [15:0] a, input logic [2:0] len);
		logic [31:0] word;
		logic [6:0] h;
		int i;
		h = port_hits(a);
		word = '0;
		if (is_wide(a)) begin
			if (h[DEV_HDD0]) word = {a, a} ^ HDD0_TAG;
			else if (h[DEV_HDD1]) word = {a, a} ^ HDD1_TAG;
			else word = {24'h0, `OPEN_BUS};
		end else begin
			for (i = 0; i < int'(len); i++) begin
				word[8 * i +: 8] = expected_byte(a + 16'(i)); // little endian
			end
		end
		return word;
	endfunction

	function automatic int expected_strobes(input logic [15:0] a, input logic [2:0] len,
		input int dev);
		int n;
		int i;
		logic [6:0] h;
		n = 0;
		if (is_wide(a)) begin
			h = port_hits(a);
			n = h[dev] ? 1 : 0;
		end else begin
			for (i = 0; i < int'(len); i++) begin
				h = port_hits(a + 16'(i));
				if (h[dev]) n++;
			end
		end
		return n;
	endfunction

	task automatic run_access(input logic is_write, input logic [15:0] addr,
		input logic [2:0] len, input logic [31:0] wdata);
		int rd_before [6];
		int wr_before [6];
		int cycles;
		int beats;
		int exp_n;
		int size_start;
		logic done;
		beats = is_wide(addr) ? 1 : int'(len);
		@(negedge clk_sys);
		for (int d = 0; d < 6; d++) begin
			rd_before[d] = rd_count[d];
			wr_before[d] = wr_count[d];
		end
		size_start = strobe_sizes.size();
		if (is_write) begin
			cpu_write_address = addr;
			cpu_write_length = len;
			cpu_write_data = wdata;
			cpu_write_do = 1'b1;
		end else begin
			exp_read_data = expected_read(addr, len);
			issued_reads++;
			cpu_read_address = addr;
			cpu_read_length = len;
			cpu_read_do = 1'b1;
		end
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			cpu_read_do = 1'b0;
			cpu_write_do = 1'b0;
			cycles++;
			done = is_write ? cpu_write_done : cpu_read_done;
			if ((is_write ? cpu_read_done : cpu_write_done) == 1'b1) begin
				abort_run($sformatf("wrong done pulse for the access at port %h", addr));
			end
			if (!done && cycles > 3 * beats + 5) begin
				abort_run($sformatf("no done pulse for the access at port %h", addr));
			end
		end
		check_value("done latency", cycles, 3 * beats + 1);
		for (int d = 0; d < 6; d++) begin
			exp_n = expected_strobes(addr, len, d);
			check_value({dev_names[d], "_read count"}, rd_count[d] - rd_before[d],
				is_write ? 0 : exp_n);
			check_value({dev_names[d], "_write count"}, wr_count[d] - wr_before[d],
				is_write ? exp_n : 0);
		end
		for (int i = size_start; i < strobe_sizes.size(); i++) begin
			check_value("dev_datasize", {29'h0, strobe_sizes[i]},
				is_wide(addr) ? {29'h0, len} : 32'd1);
		end
	endtask

	// read data compare at each done
	always @(negedge clk_sys) begin
		if (cpu_read_done) begin
			if (checked_reads >= issued_reads) begin
				abort_run("read done pulse without a pending read request");
			end else begin
				check_value("cpu_read_data", cpu_read_data, exp_read_data);
				checked_reads++;
			end
		end
	end

	initial begin
		#((ACCESS_COUNT * CYCLES_PER_ACCESS + 10) * CLK_PERIOD);
		abort_run("watchdog expired before the tests completed");
	end

	initial begin
		logic [15:0] single_ports [SINGLE_READS];
		logic [15:0] span_addr [SPAN_READS];
		logic [2:0] span_len [SPAN_READS];
		logic [31:0] rnd;
		logic [15:0] addr;
		int start;
		single_ports = '{16'h03F0, 16'h03F2, 16'h03F5, 16'h03F7, 16'h0040, 16'h0041, 16'h0042,
			16'h0043, 16'h0061, 16'h0020, 16'h0021, 16'h00A0, 16'h00A1, 16'h0070, 16'h0071};
		span_addr = '{16'h0042, 16'h0043, 16'h0040, 16'h001E, 16'h0070, 16'h0060, 16'h00A0,
			16'h03F4};
		span_len = '{3'd2, 3'd2, 3'd4, 3'd4, 3'd4, 3'd2, 3'd4, 3'd2};
		seed = 32'h6d6a;
		issued_reads = 0;
		reset = 1'b1;
		cpu_read_do = 1'b0;
		cpu_read_address = '0;
		cpu_read_length = '0;
		cpu_write_do = 1'b0;
		cpu_write_address = '0;
		cpu_write_length = '0;
		cpu_write_data = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		check_value("syscfg", {24'h0, syscfg}, {24'h0, `SYSCFG_RESET});
		run_access(1'b0, `HDD0_BASE, 3'd4, '0); // first disk access clears syscfg
		check_value("syscfg", {24'h0, syscfg}, 32'h00);
		run_access(1'b0, `HDD1_BASE, 3'd4, '0);
		run_access(1'b0, `HDD0_AUX, 3'd2, '0); // bit 9 set so byte cycles
		run_access(1'b0, `HDD1_AUX, 3'd2, '0);
		check_value("syscfg", {24'h0, syscfg}, 32'h00);

		for (int i = 0; i < SINGLE_READS; i++) begin
			run_access(1'b0, single_ports[i], 3'd1, '0);
		end
		for (int i = 0; i < RANDOM_READS; i++) begin
			do begin
				rnd = $random(seed);
				addr = rnd[15:0];
			end while (port_hits(addr) != 7'd0);
			run_access(1'b0, addr, 3'd1, '0);
		end
		for (int i = 0; i < SPAN_READS; i++) begin
			run_access(1'b0, span_addr[i], span_len[i], '0);
		end

		run_access(1'b1, `SYSCTL_PORT, 3'd2, {16'h0, `SYSCTL_KEY, 8'h5C});
		check_value("syscfg", {24'h0, syscfg}, 32'h5C);
		run_access(1'b1, `SYSCTL_PORT, 3'd2, 32'h0000_775A); // bad key
		check_value("syscfg", {24'h0, syscfg}, 32'h5C);
		run_access(1'b1, `SYSCTL_PORT, 3'd1, {16'h0, `SYSCTL_KEY, 8'h33});
		check_value("syscfg", {24'h0, syscfg}, 32'h5C);
		run_access(1'b0, `HDD0_BASE, 3'd4, '0); // later disk access keeps syscfg
		check_value("syscfg", {24'h0, syscfg}, 32'h5C);
		run_access(1'b0, `SYSCTL_PORT, 3'd4, '0);

		start = pit_wr_addr.size();
		run_access(1'b1, `PIT_BASE, 3'd2, PIT_WDATA);
		check_value("pit_write count", pit_wr_addr.size() - start, 2);
		check_value("dev_address", {16'h0, pit_wr_addr[start]}, {16'h0, `PIT_BASE});
		check_value("dev_writedata", {24'h0, pit_wr_byte[start]}, {24'h0, PIT_WDATA[7:0]});
		check_value("dev_address", {16'h0, pit_wr_addr[start + 1]}, {16'h0, `PIT_BASE + 16'd1});
		check_value("dev_writedata", {24'h0, pit_wr_byte[start + 1]},
			{24'h0, PIT_WDATA[15:8]});

		@(negedge clk_sys);
		if (checked_reads == issued_reads) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("fewer read done pulses than read requests");
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/io_hub_pkg.sv
source/io_bus_control.sv
source/port_decoder.sv
source/read_mux.sv
source/sys_ctl_port.sv
source/io_hub.sv
verif/io_hub_assert.sv
verif/io_hub_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the io_hub testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -Mdir "$BUILD_DIR" \
	--top-module io_hub_tb -o io_hub_sim -f vlog.f
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

"./$BUILD_DIR/io_hub_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
